//--- Makefile
TOP = tb_pcs_rx_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+.
pcs_pkg.sv
dec_lite_rx.sv
pcs_rx_decode.sv
sync_fifo.sv
rx_frame_assembler.sv
pcs_rx_top.sv
tb_pcs_rx_top.sv

//--- dec_lite_rx.sv
// combinational block classifier; ordered sets are not decoded so ord_v_o is always low
`timescale 1ns/1ps
`default_nettype none

module dec_lite_rx #(
	parameter int IS_40G       = 0,
	parameter int HEAD_W       = 2,
	parameter int DATA_W       = 64,
	parameter int KEEP_W       = DATA_W/8,
	parameter int BLOCK_W      = 64,
	parameter int LANE0_CNT_N  = IS_40G ? 1 : BLOCK_W/(4*8),
	parameter int BLOCK_TYPE_W = 8
)(
	input  wire  [HEAD_W-1:0]      head_i, // sync header, 01 data, 10 control
	input  wire  [DATA_W-1:0]      data_i, // already descrambled

	output logic                   ctrl_v_o,
	output logic                   idle_v_o,
	output logic [LANE0_CNT_N-1:0] start_v_o,
	output logic                   term_v_o,
	output logic                   err_v_o,
	output logic                   ord_v_o,
	output logic [DATA_W-1:0]      data_o,
	output logic [KEEP_W-1:0]      keep_o
);

// block type codes, clause 49 figure 49-7
localparam logic [BLOCK_TYPE_W-1:0] BT_ERR     = 8'h1e; // all control, used for /E/
localparam logic [BLOCK_TYPE_W-1:0] BT_START_4 = 8'h33;
localparam logic [BLOCK_TYPE_W-1:0] BT_START_0 = 8'h78;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_0  = 8'h87; // no data bytes
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_1  = 8'h99;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_2  = 8'haa;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_3  = 8'hb4;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_4  = 8'hcc;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_5  = 8'hd2;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_6  = 8'he1;
localparam logic [BLOCK_TYPE_W-1:0] BT_TERM_7  = 8'hff; // seven data bytes

logic                    head_v;     // exactly one header bit set
logic                    is_ctrl;    // wellformed control header
logic                    block_nv;   // malformed block
logic                    flag_ok;    // control block with a known type
logic [BLOCK_TYPE_W-1:0] block_type;
logic                    type_none;
logic                    idle_lite;
logic                    err_lite;
logic                    ord_lite;
logic [KEEP_W-1:0]       term_lite;  // one hot on terminate position
logic [LANE0_CNT_N-1:0]  start_lite;
logic [KEEP_W-1:0]       term_v;

assign head_v     = head_i[0] ^ head_i[1];
assign is_ctrl    = head_v & head_i[1];
assign block_type = data_i[BLOCK_TYPE_W-1:0];

assign idle_lite = ~|block_type;
assign err_lite  = block_type == BT_ERR;
assign ord_lite  = 1'b0; // no ordered set support

assign term_lite[0] = block_type == BT_TERM_0;
assign term_lite[1] = block_type == BT_TERM_1;
assign term_lite[2] = block_type == BT_TERM_2;
assign term_lite[3] = block_type == BT_TERM_3;
assign term_lite[4] = block_type == BT_TERM_4;
assign term_lite[5] = block_type == BT_TERM_5;
assign term_lite[6] = block_type == BT_TERM_6;
assign term_lite[7] = block_type == BT_TERM_7;

assign start_lite[0] = block_type == BT_START_0;
generate
	if (IS_40G == 0) begin : g_start_4
		assign start_lite[1] = block_type == BT_START_4; // lane 4 start only exists at 10g
	end
endgenerate

assign type_none = ~(idle_lite | err_lite | ord_lite | (|term_lite) | (|start_lite));

// type byte only means something under a control header
assign block_nv = ~head_v | (is_ctrl & type_none);
assign flag_ok  = is_ctrl & ~block_nv;

assign term_v = term_lite & {KEEP_W{flag_ok}};

assign ctrl_v_o  = is_ctrl | block_nv; // bad blocks are treated as control
assign idle_v_o  = idle_lite & flag_ok;
assign err_v_o   = (err_lite & flag_ok) | block_nv;
assign ord_v_o   = ord_lite & flag_ok;
assign term_v_o  = |term_v;
assign start_v_o = start_lite & {LANE0_CNT_N{flag_ok}};

// one hot minus one gives the low k bits, zero when not a terminate
assign keep_o = (|term_v) ? term_v - KEEP_W'(1) : '0;

assign data_o = data_i;

endmodule

`default_nettype wire

//--- pcs_config.svh
// build-time sizes for the rx pcs; fifo depth must be a power of two and max frame bytes below 2**PCS_LEN_W - 8
`ifndef PCS_CONFIG_SVH
`define PCS_CONFIG_SVH

// decoded records held between decoder and frame assembler
`define PCS_FIFO_DEPTH 8

// longest frame in data bytes, anything longer saturates here and is errored
`define PCS_MAX_FRAME_BYTES 2047

// width of the frame byte counter
`define PCS_LEN_W 12

`endif

//--- pcs_pkg.sv
// shared rx pcs types; the record layout is fixed to a 64-bit 10g block, no 40g lanes
`default_nettype none

`include "pcs_config.svh"

package pcs_pkg;

	// one decoded 66-bit block as it travels through the fifo
	typedef struct packed {
		logic       ctrl;  // control block or malformed block
		logic       idle;  // all-idle control block
		logic [1:0] start; // bit 0 start in lane 0, bit 1 start in lane 4
		logic       term;  // terminate, byte count in keep
		logic       err;   // error block, bad header or unknown type
		logic [7:0] keep;  // low k bits set on terminate k
		logic [63:0] data; // descrambled payload, type byte in [7:0]
	} dec_blk_t;

	// frame byte count
	typedef logic [`PCS_LEN_W-1:0] frame_len_t;

endpackage

`default_nettype wire

//--- pcs_rx_decode.sv
// descrambles and classifies one block per strobe; no block lock, input must already be header aligned
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_decode import pcs_pkg::*; (
	input  wire         clk,
	input  wire         rst_i,
	input  wire         blk_valid_i, // one block per high cycle
	input  wire  [1:0]  head_i,      // sync header, never scrambled
	input  wire  [63:0] data_i,      // scrambled payload, bit 0 first on the line

	output logic        blk_wr_o,    // one cycle after the strobe
	output dec_blk_t    blk_o
);

// x^58 + x^39 + 1 self-synchronizing descrambler
localparam int TAP_A  = 39;
localparam int TAP_B  = 58;
localparam int DATA_W = 64;

logic [TAP_B-1:0]        scr_q;    // last 58 received bits, [TAP_B-1] newest
logic [DATA_W+TAP_B-1:0] scr_ext;  // history followed by the current block
logic [DATA_W-1:0]       descr;
dec_blk_t                rec;

logic              dec_ctrl;
logic              dec_idle;
logic [1:0]        dec_start;
logic              dec_term;
logic              dec_err;
logic [DATA_W-1:0] dec_data;
logic [7:0]        dec_keep;

assign scr_ext = {data_i, scr_q};

// bit i sits at scr_ext[i+58], so taps land at i+19 and i
assign descr = data_i ^ scr_ext[TAP_B-TAP_A +: DATA_W] ^ scr_ext[0 +: DATA_W];

dec_lite_rx #(
	.IS_40G      (0),
	.HEAD_W      (2),
	.DATA_W      (DATA_W),
	.KEEP_W      (8),
	.BLOCK_W     (64),
	.LANE0_CNT_N (2),
	.BLOCK_TYPE_W(8)
) i_dec_lite_rx (
	.head_i   (head_i),
	.data_i   (descr),
	.ctrl_v_o (dec_ctrl),
	.idle_v_o (dec_idle),
	.start_v_o(dec_start),
	.term_v_o (dec_term),
	.err_v_o  (dec_err),
	.ord_v_o  (),          // ordered sets not used
	.data_o   (dec_data),
	.keep_o   (dec_keep)
);

always_comb begin
	rec       = '0;
	rec.ctrl  = dec_ctrl;
	rec.idle  = dec_idle;
	rec.start = dec_start;
	rec.term  = dec_term;
	rec.err   = dec_err;
	rec.keep  = dec_keep;
	rec.data  = dec_data;
end

// control state, write strobe and descrambler history
always_ff @(posedge clk) begin
	if (rst_i) begin
		blk_wr_o <= 1'b0;
		scr_q    <= '0;
	end else begin
		blk_wr_o <= blk_valid_i;
		if (blk_valid_i)
			scr_q <= data_i[DATA_W-1 -: TAP_B]; // history is the received line bits
	end
end

always_ff @(posedge clk) begin
	if (blk_valid_i)
		blk_o <= rec;
end

endmodule

`default_nettype wire

//--- pcs_rx_top.sv
// rx pcs from aligned 66-bit blocks to frame reports; no block lock, overflow only flags lost blocks
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module pcs_rx_top import pcs_pkg::*; (
	input  wire         clk,
	input  wire         rst_i,
	input  wire         blk_valid_i,
	input  wire  [1:0]  head_i,
	input  wire  [63:0] data_i,
	input  wire         hold_i,      // downstream back-pressure

	output logic        frame_done_o,
	output frame_len_t  frame_len_o,
	output logic        frame_err_o,
	output logic        overflow_o   // sticky, fifo dropped a block
);

logic     blk_wr;    // decoder write strobe
dec_blk_t blk;       // decoded record into the fifo
dec_blk_t fifo_head; // oldest record
logic     fifo_empty;
logic     pop;

pcs_rx_decode i_pcs_rx_decode (
	.clk        (clk),
	.rst_i      (rst_i),
	.blk_valid_i(blk_valid_i),
	.head_i     (head_i),
	.data_i     (data_i),
	.blk_wr_o   (blk_wr),
	.blk_o      (blk)
);

sync_fifo #(
	.T    (dec_blk_t),
	.DEPTH(`PCS_FIFO_DEPTH)
) i_sync_fifo (
	.clk       (clk),
	.rst_i     (rst_i),
	.wr_i      (blk_wr),
	.wr_data_i (blk),
	.rd_i      (pop),
	.rd_data_o (fifo_head),
	.empty_o   (fifo_empty),
	.overflow_o(overflow_o)
);

rx_frame_assembler i_rx_frame_assembler (
	.clk         (clk),
	.rst_i       (rst_i),
	.hold_i      (hold_i),
	.empty_i     (fifo_empty),
	.blk_i       (fifo_head),
	.pop_o       (pop),
	.frame_done_o(frame_done_o),
	.frame_len_o (frame_len_o),
	.frame_err_o (frame_err_o)
);

endmodule

`default_nettype wire

//--- rx_frame_assembler.sv
// counts data bytes per frame from start to terminate; lost blocks upstream are not detected here
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module rx_frame_assembler import pcs_pkg::*; (
	input  wire           clk,
	input  wire           rst_i,
	input  wire           hold_i,       // level, stops popping
	input  wire           empty_i,
	input  wire dec_blk_t blk_i,        // head record of the fifo

	output logic          pop_o,
	output logic          frame_done_o, // one cycle per closed frame
	output frame_len_t    frame_len_o,
	output logic          frame_err_o
);

localparam frame_len_t MAX_LEN = frame_len_t'(`PCS_MAX_FRAME_BYTES);

logic               in_frame_q;
logic               in_frame_d;
frame_len_t         len_q;
frame_len_t         len_d;
logic               err_q;
logic               err_d;
logic               done_d;
logic               done_err_d;
frame_len_t         done_len_d;
logic [3:0]         add;    // bytes carried by this block
logic [`PCS_LEN_W:0] sum;   // one extra bit so overflow is visible
logic               sat;

function automatic logic [3:0] popcnt8(input logic [7:0] v);
	logic [3:0] c;
	c = '0;
	for (int i = 0; i < 8; i++) begin
		c = c + {3'b000, v[i]};
	end
	return c;
endfunction

assign pop_o = ~empty_i & ~hold_i;

assign add = blk_i.ctrl ? popcnt8(blk_i.keep) : 4'd8; // data block is always 8
assign sum = {1'b0, len_q} + {{(`PCS_LEN_W-3){1'b0}}, add};
assign sat = sum > {1'b0, MAX_LEN};

always_comb begin
	in_frame_d = in_frame_q;
	len_d      = len_q;
	err_d      = err_q;
	done_d     = 1'b0;
	done_len_d = len_q;
	done_err_d = err_q;
	if (pop_o) begin
		if (|blk_i.start) begin
			// start inside a frame closes it as broken
			if (in_frame_q) begin
				done_d     = 1'b1;
				done_len_d = len_q;
				done_err_d = 1'b1;
			end
			in_frame_d = 1'b1;
			len_d      = blk_i.start[0] ? frame_len_t'(7) : frame_len_t'(3);
			err_d      = 1'b0;
		end else if (in_frame_q) begin
			if (!blk_i.ctrl || blk_i.term) begin
				len_d = sat ? MAX_LEN : sum[`PCS_LEN_W-1:0];
				err_d = err_q | sat;
			end
			if (blk_i.err || blk_i.idle)
				err_d = 1'b1; // idle mid frame counts as broken too
			if (blk_i.term) begin
				done_d     = 1'b1;
				done_len_d = len_d;
				done_err_d = err_d;
				in_frame_d = 1'b0;
			end
		end
		// outside a frame only a start matters
	end
end

always_ff @(posedge clk) begin
	if (rst_i) begin
		in_frame_q   <= 1'b0;
		err_q        <= 1'b0;
		frame_done_o <= 1'b0;
		frame_err_o  <= 1'b0;
	end else begin
		in_frame_q   <= in_frame_d;
		err_q        <= err_d;
		frame_done_o <= done_d;
		frame_err_o  <= done_d & done_err_d; // low between reports
	end
end

always_ff @(posedge clk) begin
	len_q <= len_d;
	if (done_d)
		frame_len_o <= done_len_d;
end

// a report carries at least the lane 4 start bytes and never more than the cap
a_len_range: assert property (@(posedge clk) disable iff (rst_i)
	frame_done_o |-> (frame_len_o >= frame_len_t'(3) && frame_len_o <= MAX_LEN));

endmodule

`default_nettype wire

//--- sync_fifo.sv
// show-ahead fifo, DEPTH must be a power of two and at least 2; writes while full are dropped
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 8
)(
	input  wire   clk,
	input  wire   rst_i,
	input  wire   wr_i,
	input  wire T wr_data_i,
	input  wire   rd_i,      // only while not empty

	output T      rd_data_o, // oldest entry, valid while empty_o is low
	output logic  empty_o,
	output logic  overflow_o // sticky until reset
);

localparam int AW = $clog2(DEPTH);
localparam int CW = $clog2(DEPTH+1);

T              mem [DEPTH];
logic [AW-1:0] wr_ptr_q;
logic [AW-1:0] rd_ptr_q;
logic [CW-1:0] cnt_q;
logic          full;
logic          do_wr;
logic          do_rd;

assign empty_o = cnt_q == '0;
assign full    = cnt_q == CW'(DEPTH);
assign do_rd   = rd_i & ~empty_o;
assign do_wr   = wr_i & (~full | do_rd); // a read frees the slot this cycle

assign rd_data_o = mem[rd_ptr_q];

always_ff @(posedge clk) begin
	if (rst_i) begin
		wr_ptr_q   <= '0;
		rd_ptr_q   <= '0;
		cnt_q      <= '0;
		overflow_o <= 1'b0;
	end else begin
		if (do_wr)
			wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at DEPTH
		if (do_rd)
			rd_ptr_q <= rd_ptr_q + 1'b1;
		case ({do_wr, do_rd})
			2'b10:   cnt_q <= cnt_q + 1'b1;
			2'b01:   cnt_q <= cnt_q - 1'b1;
			default: cnt_q <= cnt_q;
		endcase
		if (wr_i & ~do_wr)
			overflow_o <= 1'b1; // record lost
	end
end

always_ff @(posedge clk) begin
	if (do_wr)
		mem[wr_ptr_q] <= wr_data_i;
end

// consumer must look at empty before popping
a_no_rd_empty: assert property (@(posedge clk) disable iff (rst_i)
	!(rd_i && empty_o));

a_cnt_bound: assert property (@(posedge clk) disable iff (rst_i)
	cnt_q <= CW'(DEPTH));

endmodule

`default_nettype wire

//--- tb_pcs_rx_top.sv
// self-checking testbench; seeded stimulus, blocks lost on overflow are only checked through overflow_o
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module tb_pcs_rx_top import pcs_pkg::*; ();

typedef enum int {K_DATA, K_IDLE, K_ERR, K_START0, K_START4, K_TERM, K_BADHDR} kind_t;

localparam int MAX_LEN = `PCS_MAX_FRAME_BYTES;

logic        clk;
logic        rst_i;
logic        blk_valid_i;
logic [1:0]  head_i;
logic [63:0] data_i;
logic        hold_i;
logic        frame_done_o;
frame_len_t  frame_len_o;
logic        frame_err_o;
logic        overflow_o;

integer      seed;
logic [57:0] tx_scr;        // scrambler history, [57] newest line bit
logic        ref_in_frame;
int          ref_len;
logic        ref_err;
frame_len_t  exp_len_q[$];  // expected reports in order
logic        exp_err_q[$];
string       test_name;
int          cyc = 0;
int          budget = 0;    // driven blocks, hold and reset cycles

pcs_rx_top i_pcs_rx_top (
	.clk         (clk),
	.rst_i       (rst_i),
	.blk_valid_i (blk_valid_i),
	.head_i      (head_i),
	.data_i      (data_i),
	.hold_i      (hold_i),
	.frame_done_o(frame_done_o),
	.frame_len_o (frame_len_o),
	.frame_err_o (frame_err_o),
	.overflow_o  (overflow_o)
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

task automatic stop_failed();
	$display("TESTBENCH FAILED");
	$fatal(1, "run stopped");
endtask

// x^58 + x^39 + 1 scrambler, line bit 0 first
function automatic logic [63:0] scramble(input logic [63:0] p);
	logic [121:0] ext;
	logic [63:0]  s;
	ext = {64'd0, tx_scr};
	for (int i = 0; i < 64; i++) begin
		s[i]       = p[i] ^ ext[i+19] ^ ext[i]; // 39 and 58 bits back
		ext[i+58]  = s[i];
	end
	tx_scr = ext[121:64];
	return s;
endfunction

function automatic logic [7:0] term_type(input int k);
	case (k)
		0:       return 8'h87;
		1:       return 8'h99;
		2:       return 8'haa;
		3:       return 8'hb4;
		4:       return 8'hcc;
		5:       return 8'hd2;
		6:       return 8'he1;
		default: return 8'hff;
	endcase
endfunction

// frame tracker from the byte rules; returns {done, err, len}
function automatic logic [`PCS_LEN_W+1:0] ref_block(input kind_t kind, input int k);
	logic done;
	logic derr;
	int   dlen;
	int   add;
	done = 1'b0;
	derr = 1'b0;
	dlen = 0;
	add  = 0;
	if (kind == K_START0 || kind == K_START4) begin
		if (ref_in_frame) begin
			done = 1'b1; // restart closes the open frame broken
			dlen = ref_len;
			derr = 1'b1;
		end
		ref_in_frame = 1'b1;
		ref_len      = (kind == K_START0) ? 7 : 3;
		ref_err      = 1'b0;
	end else if (ref_in_frame) begin
		if (kind == K_DATA)
			add = 8;
		else if (kind == K_TERM)
			add = k;
		if (ref_len + add > MAX_LEN) begin
			ref_len = MAX_LEN; // saturate and mark
			ref_err = 1'b1;
		end else
			ref_len = ref_len + add;
		if (kind == K_ERR || kind == K_IDLE || kind == K_BADHDR)
			ref_err = 1'b1;
		if (kind == K_TERM) begin
			done         = 1'b1;
			dlen         = ref_len;
			derr         = ref_err;
			ref_in_frame = 1'b0;
		end
	end
	return {done, derr, frame_len_t'(dlen)};
endfunction

task automatic send_block(input kind_t kind, input int k);
	logic [63:0]           p;
	logic [1:0]            h;
	logic [`PCS_LEN_W+1:0] r;
	p = {$random(seed), $random(seed)};
	h = 2'b10;
	case (kind)
		K_DATA:   h = 2'b01;
		K_IDLE:   p = '0;
		K_ERR:    p = {{8{7'h1e}}, 8'h1e};
		K_START0: p[7:0] = 8'h78;
		K_START4: p[7:0] = 8'h33;
		K_TERM:   p[7:0] = term_type(k);
		default:  h = k[0] ? 2'b11 : 2'b00; // malformed header
	endcase
	@(negedge clk);
	blk_valid_i = 1'b1;
	head_i      = h;
	data_i      = scramble(p);
	r = ref_block(kind, k);
	if (r[`PCS_LEN_W+1]) begin
		exp_len_q.push_back(r[`PCS_LEN_W-1:0]);
		exp_err_q.push_back(r[`PCS_LEN_W]);
	end
	budget++;
endtask

task automatic idle_cycles(input int n);
	repeat (n) begin
		@(negedge clk);
		blk_valid_i = 1'b0;
	end
	budget += n;
endtask

// start, nd data blocks, terminate k, then 0..3 idle blocks
task automatic send_frame(input logic lane4, input int nd, input int k);
	send_block(lane4 ? K_START4 : K_START0, 0);
	repeat (nd) send_block(K_DATA, 0);
	send_block(K_TERM, k);
	repeat ($unsigned($random(seed)) % 4) send_block(K_IDLE, 0);
endtask

task automatic hold_for(input int n);
	@(negedge clk);
	hold_i = 1'b1;
	repeat (n) @(negedge clk);
	hold_i = 1'b0;
	budget += n;
endtask

task automatic drain();
	@(negedge clk);
	blk_valid_i = 1'b0;
	while (exp_len_q.size() != 0) @(negedge clk);
	repeat (4) @(negedge clk);
endtask

task automatic do_reset();
	rst_i        = 1'b1;
	blk_valid_i  = 1'b0;
	hold_i       = 1'b0;
	tx_scr       = '0; // descrambler restarts from zero too
	ref_in_frame = 1'b0;
	ref_len      = 0;
	ref_err      = 1'b0;
	repeat (8) @(negedge clk);
	rst_i = 1'b0;
	budget += 8;
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	assert (act === exp) else begin
		$display("** Error %s: %s expected %0b, actual %0b", test_name, what, exp, act);
		stop_failed();
	end
endtask

// compares every report against the oldest expected frame
always @(posedge clk) begin
	frame_len_t el;
	logic       ee;
	if (!rst_i && frame_done_o) begin
		assert (exp_len_q.size() != 0) else begin
			$display("%s: frame reported while none was expected", test_name);
			stop_failed();
		end
		if (exp_len_q.size() != 0) begin
			el = exp_len_q.pop_front();
			ee = exp_err_q.pop_front();
			assert (frame_len_o == el) else begin
				$display("** Error %s: frame length expected %0d, actual %0d",
					test_name, el, frame_len_o);
				stop_failed();
			end
			assert (frame_err_o == ee) else begin
				$display("** Error %s: frame error expected %0b, actual %0b",
					test_name, ee, frame_err_o);
				stop_failed();
			end
		end
	end
end

always @(posedge clk) begin
	cyc++;
	if (cyc > budget + 200) begin
		$display("timeout: run still busy after %0d cycles", cyc);
		stop_failed();
	end
end

initial begin
	seed        = 32'h6ffc_7663;
	test_name   = "reset";
	rst_i       = 1'b1;
	blk_valid_i = 1'b0;
	hold_i      = 1'b0;
	head_i      = '0;
	data_i      = '0;
	do_reset();
	check_flag("overflow", 1'b0, overflow_o);

	test_name = "lengths"; // both start lanes, every terminate position
	for (int lane = 0; lane < 2; lane++) begin
		for (int k = 0; k < 8; k++) begin
			send_frame(lane[0], $unsigned($random(seed)) % 12, k);
		end
	end
	send_frame(1'b0, 60, 5);
	drain();

	test_name = "errors";
	send_block(K_START0, 0);
	send_block(K_DATA, 0);
	send_block(K_ERR, 0);
	send_block(K_TERM, 3);
	send_block(K_START4, 0);
	send_block(K_BADHDR, 0);  // header 00
	send_block(K_DATA, 0);
	send_block(K_TERM, 6);
	send_block(K_START0, 0);
	send_block(K_BADHDR, 1);  // header 11
	send_block(K_TERM, 7);
	send_block(K_START4, 0);
	send_block(K_IDLE, 0);    // idle mid frame
	send_block(K_TERM, 1);
	drain();

	test_name = "restart";
	send_block(K_DATA, 0);    // stray blocks between frames
	send_block(K_TERM, 4);
	send_block(K_ERR, 0);
	send_block(K_START0, 0);
	send_block(K_DATA, 0);
	send_block(K_DATA, 0);
	send_block(K_START4, 0);  // closes the open frame
	send_block(K_DATA, 0);
	send_block(K_TERM, 2);
	send_block(K_TERM, 5);
	drain();

	test_name = "saturate";
	send_frame(1'b0, 300, 7);
	drain();

	test_name = "hold_short"; // every hold shorter than the fifo
	for (int n = 3; n < `PCS_FIFO_DEPTH; n += 2) begin
		fork
			send_frame(n[1], 8, n);
			hold_for(n);
		join
		idle_cycles(`PCS_FIFO_DEPTH);
	end
	drain();
	check_flag("overflow", 1'b0, overflow_o);

	test_name = "overflow";
	fork
		hold_for(2 * `PCS_FIFO_DEPTH);
		repeat (2 * `PCS_FIFO_DEPTH + 4) send_block(K_IDLE, 0);
	join
	idle_cycles(2);
	check_flag("overflow", 1'b1, overflow_o);
	idle_cycles(20);
	check_flag("overflow sticky", 1'b1, overflow_o);
	do_reset();
	check_flag("overflow after reset", 1'b0, overflow_o);

	test_name = "after_reset";
	send_frame(1'b0, 4, 2);
	drain();

	if (exp_len_q.size() != 0) begin
		$display("%s: %0d frames were never reported", test_name, exp_len_q.size());
		stop_failed();
	end else begin
		$display("TESTBENCH PASSED");
		$finish;
	end
end

endmodule

`default_nettype wire
